/* cnn_fc_top.f */
+incdir+include
source/cnn_fc_pkg.sv
source/fc_result_if.sv
source/dot_product.sv
source/fc_layer.sv
source/class_argmax.sv
source/cnn_fc_top.sv
bench/tb_cnn_fc_top.sv

/* run_sim.sh */
#!/bin/bash
# Compile and run the classifier testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_cnn_fc_top \
    -f cnn_fc_top.f

./obj_dir/Vtb_cnn_fc_top | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0

/* bench/tb_cnn_fc_top.sv */
`timescale 1ns/1ns

module tb_cnn_fc_top
    import cnn_fc_pkg::*;
();

    localparam int RESET_CYCLES    = 4;
    localparam int NUM_RANDOM      = 12;
    localparam int NUM_TESTS       = 1 + NUM_IN + 2 + 1 + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_TESTS + TOP_LATENCY + 20;

    logic                      clk;
    logic                      reset_n;
    logic                      i_in_valid;
    logic [FMAP_W-1:0]         i_in_fmap;
    logic                      o_ot_valid;
    logic [CLASS_W-1:0]        o_ot_class;
    logic signed [SCORE_W-1:0] o_ot_score;

    string             t_name [NUM_TESTS];
    logic [FMAP_W-1:0] t_fmap [NUM_TESTS];

    // expected results in input order
    int exp_idx_q[$];
    int exp_class_q[$];
    int exp_score_q[$];
    int exp_cycle_q[$];

    int seed = 48;
    int cycle = 0;
    int pass_count = 0;
    int fail_count = 0;
    bit input_seen = 1'b0;
    bit tie_found = 1'b0;

    cnn_fc_top dut_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_fmap  (i_in_fmap),
        .o_ot_valid (o_ot_valid),
        .o_ot_class (o_ot_class),
        .o_ot_score (o_ot_score)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ============================================================
    // reference model
    // ============================================================

    function automatic int model_score(input logic [FMAP_W-1:0] fmap, input int c);
        int acc;
        acc = int'(FC_BIAS[c]);
        for (int k = 0; k < NUM_IN; k++) begin
            acc += int'($signed(fmap[k*ACT_W +: ACT_W])) * int'(FC_WEIGHTS[c][k]);
        end
        return acc;
    endfunction

    // lowest index wins a tie
    task automatic model_result(input logic [FMAP_W-1:0] fmap, output int cls,
                                output int score, output int ties);
        int s;
        cls = 0;
        score = model_score(fmap, 0);
        ties = 1;
        for (int c = 1; c < NUM_CLASS; c++) begin
            s = model_score(fmap, c);
            if (s > score) begin
                cls = c;
                score = s;
                ties = 1;
            end else if (s == score) begin
                ties++;
            end
        end
    endtask

    task automatic build_table();
        logic [FMAP_W-1:0] v;
        int cls;
        int score;
        int ties;
        int n;
        n = 0;
        t_name[n] = "zero";
        t_fmap[n] = '0;
        n++;
        for (int k = 0; k < NUM_IN; k++) begin
            v = '0;
            v[k*ACT_W +: ACT_W] = 8'sd1;
            t_name[n] = $sformatf("onehot_%0d", k);
            t_fmap[n] = v;
            n++;
        end
        t_name[n] = "all_pos_max";
        t_fmap[n] = {NUM_IN{8'h7f}};
        n++;
        t_name[n] = "all_neg_max";
        t_fmap[n] = {NUM_IN{8'h80}};
        n++;
        // search single nonzero activations for a tied maximum
        t_name[n] = "tie";
        t_fmap[n] = '0;
        for (int k = 0; k < NUM_IN && !tie_found; k++) begin
            for (int a = -128; a < 128 && !tie_found; a++) begin
                v = '0;
                v[k*ACT_W +: ACT_W] = ACT_W'(a);
                model_result(v, cls, score, ties);
                if (ties > 1) begin
                    t_fmap[n] = v;
                    tie_found = 1'b1;
                end
            end
        end
        n++;
        for (int r = 0; r < NUM_RANDOM; r++) begin
            for (int w = 0; w < FMAP_W / 32; w++) begin
                v[w*32 +: 32] = $random(seed);
            end
            t_name[n] = $sformatf("random_%0d", r);
            t_fmap[n] = v;
            n++;
        end
    endtask

    // ============================================================
    // checking and reporting
    // ============================================================

    task automatic check_value(input string what, input longint expected,
                               input longint actual, inout bit ok);
        if (expected != actual) begin
            $display("ERR %s expected %0d actual %0d", what, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %-14s %s", name, ok ? "ok" : "failed");
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        int idx;
        bit ok;
        if (reset_n && o_ot_valid) begin
            if (!input_seen) begin
                $display("output strobe appeared before any input was applied");
                fail_count++;
            end else if (exp_idx_q.size() == 0) begin
                $display("output strobe appeared with no input outstanding");
                fail_count++;
            end else begin
                idx = exp_idx_q.pop_front();
                ok = 1'b1;
                check_value({t_name[idx], " class"}, exp_class_q.pop_front(),
                            longint'(o_ot_class), ok);
                check_value({t_name[idx], " score"}, exp_score_q.pop_front(),
                            longint'(o_ot_score), ok);
                check_value({t_name[idx], " latency"}, TOP_LATENCY,
                            cycle - exp_cycle_q.pop_front(), ok);
                report_test(t_name[idx], ok);
            end
        end
    end

    // ============================================================
    // stimulus
    // ============================================================

    task automatic drive_entry(input int idx);
        int cls;
        int score;
        int ties;
        model_result(t_fmap[idx], cls, score, ties);
        i_in_valid = 1'b1;
        i_in_fmap = t_fmap[idx];
        input_seen = 1'b1;
        exp_idx_q.push_back(idx);
        exp_class_q.push_back(cls);
        exp_score_q.push_back(score);
        exp_cycle_q.push_back(cycle);
    endtask

    // latency is fixed, so results are due within a few cycles
    task automatic wait_results();
        for (int w = 0; w < TOP_LATENCY + 2 && exp_idx_q.size() != 0; w++) begin
            @(negedge clk);
        end
    endtask

    initial begin
        bit ok;
        reset_n = 1'b0;
        i_in_valid = 1'b0;
        i_in_fmap = '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        ok = 1'b1;
        check_value("after_reset valid", 0, longint'(o_ot_valid), ok);
        check_value("after_reset class", 0, longint'(o_ot_class), ok);
        check_value("after_reset score", 0, longint'(o_ot_score), ok);
        report_test("after_reset", ok);
        if (!tie_found) begin
            $display("no vector with tied class scores was found");
            fail_count++;
        end
        // first vector on its own, the rest back to back
        drive_entry(0);
        @(negedge clk);
        i_in_valid = 1'b0;
        wait_results();
        for (int i = 1; i < NUM_TESTS; i++) begin
            drive_entry(i);
            @(negedge clk);
        end
        i_in_valid = 1'b0;
        wait_results();
        repeat (2) @(negedge clk);
        if (exp_idx_q.size() != 0) begin
            $display("%0d results never arrived", exp_idx_q.size());
            fail_count += exp_idx_q.size();
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, output strobes stopped arriving with %0d results missing",
                 exp_idx_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* source/cnn_fc_top.sv */
`timescale 1ns/1ns

module cnn_fc_top
    import cnn_fc_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_in_valid,
    input  logic [FMAP_W-1:0]         i_in_fmap,
    output logic                      o_ot_valid,
    output logic [CLASS_W-1:0]        o_ot_class,
    output logic signed [SCORE_W-1:0] o_ot_score
);

    // ============================================================
    // fully connected layer into argmax
    // ============================================================

    // scores and their strobe between the two stages
    fc_result_if res_if ();

    // 2 cycle layer
    fc_layer u_fc_layer (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_fmap  (i_in_fmap),
        .res        (res_if)
    );

    // 1 cycle selection
    class_argmax u_class_argmax (
        .clk        (clk),
        .reset_n    (reset_n),
        .res        (res_if),
        .o_ot_valid (o_ot_valid),
        .o_ot_class (o_ot_class),
        .o_ot_score (o_ot_score)
    );

endmodule

/* source/class_argmax.sv */
`timescale 1ns/1ns

module class_argmax
    import cnn_fc_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    fc_result_if.consumer             res,
    output logic                      o_ot_valid,
    output logic [CLASS_W-1:0]        o_ot_class,
    output logic signed [SCORE_W-1:0] o_ot_score
);

    logic signed [SCORE_W-1:0] w_best_score;
    logic [CLASS_W-1:0]        w_best_class;

    // ============================================================
    // compare the three signed scores
    // ============================================================

    // strict greater than, so a tie keeps the lower index
    always_comb begin
        w_best_score = res.score0;
        w_best_class = '0;
        if (res.score1 > w_best_score) begin
            w_best_score = res.score1;
            w_best_class = CLASS_W'(1);
        end
        if (res.score2 > w_best_score) begin
            w_best_score = res.score2;
            w_best_class = CLASS_W'(2);
        end
    end

    // ============================================================
    // output register
    // ============================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
            o_ot_class <= '0;
            o_ot_score <= '0;
        end else begin
            o_ot_valid <= res.valid;
            // result holds between strobes
            if (res.valid) begin
                o_ot_class <= w_best_class;
                o_ot_score <= w_best_score;
            end
        end
    end

    a_class_range : assert property (
        @(posedge clk) disable iff (!reset_n)
        o_ot_valid |-> (o_ot_class < CLASS_W'(NUM_CLASS))
    ) else $error("class_argmax reported class index %0d out of range", o_ot_class);

endmodule

/* source/fc_layer.sv */
`timescale 1ns/1ns

module fc_layer
    import cnn_fc_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_in_valid,
    input  logic [FMAP_W-1:0] i_in_fmap,
    fc_result_if.producer     res
);

    logic [FC_LATENCY-1:0]     r_valid;
    logic [WVEC_W-1:0]         w_weights [NUM_CLASS];
    logic signed [SCORE_W-1:0] w_score [NUM_CLASS];

    // ============================================================
    // valid strobe shifted alongside the data
    // ============================================================

    // bit 0 marks the product stage, top bit the score stage
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= '0;
        end else begin
            r_valid <= {r_valid[FC_LATENCY-2:0], i_in_valid};
        end
    end

    // ============================================================
    // one dot product per class
    // ============================================================

    for (genvar c = 0; c < NUM_CLASS; c++) begin : g_class
        // flatten this class's weight row, element k at bits k*7
        for (genvar k = 0; k < NUM_IN; k++) begin : g_pack
            assign w_weights[c][k*WGT_W +: WGT_W] = FC_WEIGHTS[c][k];
        end

        dot_product u_dot_product (
            .clk       (clk),
            .reset_n   (reset_n),
            .i_valid   (i_in_valid),
            .i_fmap    (i_in_fmap),
            .i_weights (w_weights[c]),
            .i_bias    (FC_BIAS[c]),
            .i_sum_en  (r_valid[0]),
            .o_score   (w_score[c])
        );
    end

    assign res.valid  = r_valid[FC_LATENCY-1];
    assign res.score0 = w_score[0];
    assign res.score1 = w_score[1];
    assign res.score2 = w_score[2];

    // scores come out a fixed FC_LATENCY cycles after the input
    a_fc_latency : assert property (
        @(posedge clk) disable iff (!reset_n)
        res.valid == $past(i_in_valid, FC_LATENCY)
    ) else $error("fc_layer score strobe out of step with input strobe");

endmodule

/* source/dot_product.sv */
`timescale 1ns/1ns

module dot_product
    import cnn_fc_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_valid,
    input  logic [FMAP_W-1:0]         i_fmap,
    input  logic [WVEC_W-1:0]         i_weights,
    input  logic signed [WGT_W-1:0]   i_bias,
    input  logic                      i_sum_en,
    output logic signed [SCORE_W-1:0] o_score
);

    logic signed [PROD_W-1:0]  w_prod [NUM_IN];
    logic signed [PROD_W-1:0]  r_prod [NUM_IN];
    logic signed [SCORE_W-1:0] w_sum;

    // ============================================================
    // stage one: per element products
    // ============================================================

    for (genvar k = 0; k < NUM_IN; k++) begin : g_mul
        logic signed [ACT_W-1:0] w_act;
        logic signed [WGT_W-1:0] w_wgt;

        // activation k sits at bits k*8 upward
        assign w_act = i_fmap[k*ACT_W +: ACT_W];
        assign w_wgt = i_weights[k*WGT_W +: WGT_W];

        // both operands sign extended to product width
        assign w_prod[k] = PROD_W'(w_act) * PROD_W'(w_wgt);

        always_ff @(posedge clk) begin
            if (i_valid) begin
                r_prod[k] <= w_prod[k];
            end
        end
    end

    // ============================================================
    // stage two: sum of products plus bias
    // ============================================================

    // bias seeds the sum
    always_comb begin
        w_sum = SCORE_W'(i_bias);
        for (int k = 0; k < NUM_IN; k++) begin
            w_sum = w_sum + SCORE_W'(r_prod[k]);
        end
    end

    // loads one cycle after the products
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_score <= '0;
        end else if (i_sum_en) begin
            o_score <= w_sum;
        end
    end

endmodule

/* source/fc_result_if.sv */
`timescale 1ns/1ns

interface fc_result_if
    import cnn_fc_pkg::*;
();

    // scores qualify only in the cycle valid is high
    logic                      valid;
    logic signed [SCORE_W-1:0] score0;
    logic signed [SCORE_W-1:0] score1;
    logic signed [SCORE_W-1:0] score2;

    modport producer (
        output valid,
        output score0,
        output score1,
        output score2
    );

    modport consumer (
        input valid,
        input score0,
        input score1,
        input score2
    );

endinterface

/* source/cnn_fc_pkg.sv */
package cnn_fc_pkg;

    // ============================================================
    // layer geometry
    // ============================================================

    // activations in one flattened feature vector
    localparam int NUM_IN    = 48;
    localparam int NUM_CLASS = 3;

    // ============================================================
    // data widths
    // ============================================================

    localparam int ACT_W  = 8;
    localparam int WGT_W  = 7;
    localparam int FMAP_W = NUM_IN * ACT_W;
    localparam int WVEC_W = NUM_IN * WGT_W;

    // full precision signed product
    localparam int PROD_W = ACT_W + WGT_W;

    // 48 terms grow the sum by 6 bits, the bias by one more
    localparam int SCORE_W = PROD_W + 6 + 1;

    localparam int CLASS_W = 2;

    // ============================================================
    // pipeline depth
    // ============================================================

    // products, then sum plus bias
    localparam int FC_LATENCY  = 2;
    // one more stage for the argmax
    localparam int TOP_LATENCY = FC_LATENCY + 1;

    `include "fc_weights.svh"

endpackage

/* include/fc_weights.svh */
`ifndef FC_WEIGHTS_SVH
`define FC_WEIGHTS_SVH

// ============================================================
// fixed weights of the fully connected layer
// ============================================================

// indexed [class][activation]
localparam logic signed [WGT_W-1:0] FC_WEIGHTS [NUM_CLASS][NUM_IN] = '{
    // class 0
    '{ 7'sd12, -7'sd7,  7'sd23, -7'sd30,  7'sd4,  7'sd18, -7'sd2,   7'sd9,
      -7'sd15,  7'sd27, 7'sd6,  -7'sd11,  7'sd31, -7'sd4, -7'sd22,  7'sd8,
       7'sd3,  -7'sd19, 7'sd14,  7'sd25, -7'sd9,  -7'sd1,  7'sd17, -7'sd26,
       7'sd10,  7'sd5, -7'sd13,  7'sd20, -7'sd28,  7'sd7,  7'sd2,  -7'sd16,
       7'sd21, -7'sd6, -7'sd3,   7'sd11, -7'sd24,  7'sd15, 7'sd29, -7'sd8,
      -7'sd12,  7'sd1,  7'sd19, -7'sd20,  7'sd6,  -7'sd5,  7'sd13,  7'sd24},
    // class 1
    '{-7'sd9,   7'sd16, -7'sd25, 7'sd3,   7'sd22, -7'sd14, 7'sd8,   7'sd30,
       7'sd1,  -7'sd18,  7'sd11, -7'sd7, -7'sd2,   7'sd26, -7'sd10, 7'sd5,
      -7'sd21,  7'sd14,  7'sd4, -7'sd29,  7'sd17,  7'sd9,  -7'sd6, -7'sd3,
       7'sd28, -7'sd12,  7'sd7,  7'sd19, -7'sd1,  -7'sd23,  7'sd12,  7'sd2,
      -7'sd8,   7'sd24, -7'sd16, 7'sd6,   7'sd13, -7'sd4,  -7'sd27, 7'sd10,
       7'sd18, -7'sd11,  7'sd0,  7'sd15, -7'sd19,  7'sd21, -7'sd5, -7'sd14},
    // class 2
    '{ 7'sd7,  -7'sd24,  7'sd19,  7'sd11, -7'sd3,  -7'sd16, 7'sd26, -7'sd1,
       7'sd14,  7'sd2,  -7'sd28,  7'sd9,   7'sd20, -7'sd13, 7'sd5,  -7'sd20,
       7'sd31, -7'sd5,  -7'sd10,  7'sd16,  7'sd1,   7'sd23, -7'sd17, 7'sd6,
      -7'sd4,   7'sd18,  7'sd25, -7'sd9,  -7'sd22,  7'sd12, -7'sd2,  7'sd27,
       7'sd3,  -7'sd15,  7'sd8,  -7'sd26,  7'sd10,  7'sd29, -7'sd7, -7'sd12,
      -7'sd18,  7'sd4,   7'sd22, -7'sd6,   7'sd15, -7'sd21,  7'sd9,  7'sd0}
};

// one bias per class
localparam logic signed [WGT_W-1:0] FC_BIAS [NUM_CLASS] = '{
    7'sd9, -7'sd6, -7'sd13
};

`endif
